/* include/cart_loader_cfg.svh */
/*
 * Cartridge loader configuration
 * Widths, ROM header offsets and the cheat download index
 */
`ifndef CART_LOADER_CFG_SVH
`define CART_LOADER_CFG_SVH

// ======================================================================
// Host download stream
// ======================================================================
`define CL_DL_ADDR_BITS      25
`define CL_DL_DATA_BITS      16
// Index reserved for cheat code files
`define CL_CODE_INDEX        255

// ======================================================================
// Masks, sectors and work RAM sweep
// ======================================================================
`define CL_MASK_BITS         24
`define CL_LBA_BITS          32
`define CL_FILL_ADDR_BITS    17

// ======================================================================
// ROM header layout
// ======================================================================
`define CL_COPIER_SKIP       512
// Internal header size fields, offsets without the copier header
`define CL_LOROM_SIZE_OFS    'h7FD6
`define CL_HIROM_SIZE_OFS    'hFFD6
`define CL_EXHIROM_SIZE_OFS  'h40FFD6
`define CL_DEFAULT_ROM_SIZE  12

`endif

/* source/cart_loader_pkg.sv */
/*
 * Cartridge loader shared types
 * Download beats, header word views, cheat codes and mode encodings
 */
`default_nettype none
`include "cart_loader_cfg.svh"

package cart_loader_pkg;

	// One host download write
	typedef struct packed {
		logic [`CL_DL_ADDR_BITS-1:0] addr;
		logic [`CL_DL_DATA_BITS-1:0] data;
		logic                        wr;
	} dl_beat_t;

	// Header word seen as copier header or as internal header
	typedef union packed {
		struct packed {
			logic [7:0] rom_type;
			logic [3:0] ram_size;
			logic [3:0] rom_size;
		} copier;
		struct packed {
			logic [3:0] pad;
			logic [3:0] size;
			logic [7:0] ram_byte;
		} internal;
	} dl_word_u;

	// Code layout, flags on top and replace value at the bottom
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef enum logic [2:0] {
		hdr_auto      = 3'd0,
		hdr_no_header = 3'd1,
		hdr_lorom     = 3'd2,
		hdr_hirom     = 3'd3,
		hdr_exhirom   = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		region_auto = 2'd0,
		region_ntsc = 2'd1,
		region_pal  = 2'd2
	} region_mode_e;

	typedef enum logic [1:0] {
		pat_checker_ff00 = 2'd0,
		pat_checker_6699 = 2'd1,
		pat_fill_55      = 2'd2,
		pat_fill_ff      = 2'd3
	} init_pattern_e;

endpackage

`default_nettype wire

/* source/download_router.sv */
/*
 * Download router
 * Splits the host stream into cartridge and cheat writes, marks download edges
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_loader_cfg.svh"

module download_router (
	input  wire                       clk_sys,
	input  wire                       RESET,
	input  wire cart_loader_pkg::dl_beat_t dl_beat,
	input  wire [7:0]                 dl_index,
	input  wire                       dl_active,
	output cart_loader_pkg::dl_beat_t cart_beat,
	output cart_loader_pkg::dl_beat_t code_beat,
	output logic                      cart_download,
	output logic                      dl_start,
	output logic                      dl_end
);

	logic code_sel;
	logic cart_level;

	assign code_sel   = (dl_index == 8'(`CL_CODE_INDEX));
	assign cart_level = dl_active & ~code_sel;

	always_ff @(posedge clk_sys) begin
		// Payload follows the input every cycle
		cart_beat.addr <= dl_beat.addr;
		cart_beat.data <= dl_beat.data;
		code_beat.addr <= dl_beat.addr;
		code_beat.data <= dl_beat.data;

		if (RESET) begin
			cart_beat.wr  <= 1'b0;
			code_beat.wr  <= 1'b0;
			cart_download <= 1'b0;
			dl_start      <= 1'b0;
			dl_end        <= 1'b0;
		end else begin
			cart_beat.wr  <= dl_beat.wr & cart_level;
			code_beat.wr  <= dl_beat.wr & dl_active & code_sel;
			// Registered level doubles as the previous level for the edges
			cart_download <= cart_level;
			dl_start      <= cart_level & ~cart_download;
			dl_end        <= ~cart_level & cart_download;
		end
	end

endmodule

`default_nettype wire

/* source/rom_header_parser.sv */
/*
 * ROM header parser
 * Captures size and region fields during download, derives type, masks and PAL
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_loader_cfg.svh"

module rom_header_parser (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire cart_loader_pkg::dl_beat_t cart_beat,
	input  wire                          cart_download,
	input  wire cart_loader_pkg::header_mode_e header_mode,
	input  wire cart_loader_pkg::region_mode_e region_mode,
	output logic [7:0]                   rom_type,
	output logic [`CL_MASK_BITS-1:0]     rom_mask,
	output logic [`CL_MASK_BITS-1:0]     ram_mask,
	output logic                         pal
);

	import cart_loader_pkg::*;

	localparam int AW = `CL_DL_ADDR_BITS;
	localparam logic [AW-1:0] LOROM_ADDR   = AW'(`CL_LOROM_SIZE_OFS + `CL_COPIER_SKIP);
	localparam logic [AW-1:0] HIROM_ADDR   = AW'(`CL_HIROM_SIZE_OFS + `CL_COPIER_SKIP);
	localparam logic [AW-1:0] EXHIROM_ADDR = AW'(`CL_EXHIROM_SIZE_OFS + `CL_COPIER_SKIP);
	// RAM size field follows the ROM size field
	localparam logic [AW-1:0] RAM_FIELD_GAP = AW'(2);

	dl_word_u        hdr_word;
	logic [AW-1:0]   size_addr;
	logic            internal_hdr;
	logic            hdr_wr;
	logic [3:0]      rom_size;
	logic [3:0]      ram_size;
	logic [7:0]      hdr_type;
	logic            rom_region;

	assign hdr_word = cart_beat.data;
	assign hdr_wr   = cart_download & cart_beat.wr;

	always_comb begin
		internal_hdr = 1'b1;
		case (header_mode)
			hdr_lorom:   size_addr = LOROM_ADDR;
			hdr_hirom:   size_addr = HIROM_ADDR;
			hdr_exhirom: size_addr = EXHIROM_ADDR;
			default: begin
				size_addr    = '0;
				internal_hdr = 1'b0;
			end
		endcase
	end

	// ==================================================================
	// Header field capture
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'(`CL_DEFAULT_ROM_SIZE);
			ram_size   <= 4'd0;
			hdr_type   <= 8'd0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (hdr_wr && cart_beat.addr == '0) begin
				rom_size <= 4'(`CL_DEFAULT_ROM_SIZE);
				ram_size <= 4'd0;
				hdr_type <= hdr_word.copier.rom_type;
				// Copier header carries both sizes in the low byte
				if (header_mode == hdr_auto && hdr_word[7:0] != 8'd0) begin
					rom_size <= hdr_word.copier.rom_size;
					ram_size <= hdr_word.copier.ram_size;
				end
			end
			if (hdr_wr && cart_beat.addr == AW'(2))
				rom_region <= hdr_word[8];
			if (hdr_wr && internal_hdr && cart_beat.addr == size_addr)
				rom_size <= hdr_word.internal.size;
			if (hdr_wr && internal_hdr && cart_beat.addr == size_addr + RAM_FIELD_GAP)
				ram_size <= hdr_word.internal.ram_byte[3:0];

			// Region is frozen while a cartridge streams in
			if (!cart_download)
				pal <= (region_mode == region_auto) ? rom_region : (region_mode == region_pal);
		end
	end

	// Derived outputs, one cycle behind the fields
	always_ff @(posedge clk_sys) begin
		rom_mask <= (`CL_MASK_BITS'(1024) << rom_size) - 1'b1;
		ram_mask <= (ram_size == 4'd0) ? '0 : (`CL_MASK_BITS'(1024) << ram_size) - 1'b1;
		case (header_mode)
			hdr_no_header, hdr_lorom: rom_type <= 8'd0;
			hdr_hirom:                rom_type <= 8'd1;
			hdr_exhirom:              rom_type <= 8'd2;
			default:                  rom_type <= hdr_type;
		endcase
	end

	// Forced modes never report a raw header type
	assert property (@(posedge clk_sys) disable iff (RESET)
		(rom_type > 8'd2) |-> ($past(header_mode) == hdr_auto));

endmodule

`default_nettype wire

/* source/cheat_code_assembler.sv */
/*
 * Cheat code assembler
 * Places eight download words into one code and pulses it out
 */
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire cart_loader_pkg::dl_beat_t code_beat,
	output cart_loader_pkg::cheat_code_t cheat_code,
	output logic                         code_valid
);

	// Word placement, low half first for every field
	always_ff @(posedge clk_sys) begin
		if (code_beat.wr) begin
			case (code_beat.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= code_beat.data;
				4'd2:  cheat_code.flags[31:16]   <= code_beat.data;
				4'd4:  cheat_code.addr[15:0]     <= code_beat.data;
				4'd6:  cheat_code.addr[31:16]    <= code_beat.data;
				4'd8:  cheat_code.compare[15:0]  <= code_beat.data;
				4'd10: cheat_code.compare[31:16] <= code_beat.data;
				4'd12: cheat_code.replace[15:0]  <= code_beat.data;
				4'd14: cheat_code.replace[31:16] <= code_beat.data;
				default: ;
			endcase
		end
	end

	// Last word of the group releases the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_beat.wr && (code_beat.addr[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

/* source/ram_clear_engine.sv */
/*
 * Work RAM clear engine
 * Sweeps the fill address after a download starts and drives the init pattern
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_loader_cfg.svh"

module ram_clear_engine (
	input  wire                              clk_sys,
	input  wire                              RESET,
	input  wire                              dl_start,
	input  wire cart_loader_pkg::init_pattern_e init_pattern,
	output logic                             clearing,
	output logic [`CL_FILL_ADDR_BITS-1:0]    fill_addr,
	output logic [7:0]                       wram_fill_data
);

	import cart_loader_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else if (dl_start) begin
			// A new download restarts the sweep
			clearing  <= 1'b1;
			fill_addr <= '0;
		end else if (clearing) begin
			fill_addr <= fill_addr + 1'b1;
			if (&fill_addr)
				clearing <= 1'b0;
		end else begin
			fill_addr <= '0;
		end
	end

	// Power-on patterns of the different console revisions
	always_comb begin
		case (init_pattern)
			pat_checker_ff00: wram_fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			pat_checker_6699: wram_fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			pat_fill_55:      wram_fill_data = 8'h55;
			default:          wram_fill_data = 8'hFF;
		endcase
	end

	assert property (@(posedge clk_sys) disable iff (RESET)
		!clearing |-> (fill_addr == '0));

endmodule

`default_nettype wire

/* source/backup_ram_sequencer.sv */
/*
 * Backup RAM sequencer
 * Enables save RAM per cartridge and steps sector transfers with the host
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_loader_cfg.svh"

module backup_ram_sequencer (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        cart_download,
	input  wire                        dl_start,
	input  wire                        dl_end,
	input  wire [`CL_MASK_BITS-1:0]    ram_mask,
	input  wire                        img_mounted,
	input  wire                        img_readonly,
	input  wire [63:0]                 img_size,
	input  wire                        bk_load,
	input  wire                        bk_save,
	input  wire                        sd_ack,
	output logic [`CL_LBA_BITS-1:0]    sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic                       bk_busy,
	output logic                       bk_loading,
	output logic                       bk_ena
);

	// Sectors are 512 bytes
	localparam int SECT_BITS = `CL_MASK_BITS - 9;

	logic                 old_load;
	logic                 old_save;
	logic                 old_ack;
	logic                 load_go;
	logic                 save_go;
	logic                 auto_go;
	logic                 read_run;
	logic                 ack_rise;
	logic                 ack_fall;
	logic [SECT_BITS-1:0] last_sector;

	assign load_go     = bk_load & ~old_load & bk_ena;
	assign save_go     = bk_save & ~old_save & bk_ena;
	assign auto_go     = dl_end & (|img_size) & bk_ena;
	assign read_run    = load_go | auto_go;
	assign ack_rise    = sd_ack & ~old_ack;
	assign ack_fall    = ~sd_ack & old_ack;
	assign last_sector = ram_mask[`CL_MASK_BITS-1:9];

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_ena     <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_ack;

			// Save file is mounted while the cartridge loads
			if (dl_start)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;

			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (read_run | save_go) begin
					bk_busy    <= 1'b1;
					bk_loading <= read_run;
					sd_lba     <= '0;
					sd_rd      <= read_run;
					sd_wr      <= ~read_run;
				end
			end else if (ack_fall) begin
				if (sd_lba >= `CL_LBA_BITS'(last_sector)) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	assert property (@(posedge clk_sys) disable iff (RESET) !(sd_rd && sd_wr));

endmodule

`default_nettype wire

/* source/cart_loader_top.sv */
/*
 * Cartridge loader top level
 * Download routing, header detection, cheats, RAM clear and backup RAM
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_loader_cfg.svh"

module cart_loader_top (
	input  wire                                clk_sys,
	input  wire                                RESET,
	// Host download and menu settings
	input  wire cart_loader_pkg::dl_beat_t     dl_beat,
	input  wire [7:0]                          dl_index,
	input  wire                                dl_active,
	input  wire cart_loader_pkg::header_mode_e header_mode,
	input  wire cart_loader_pkg::region_mode_e region_mode,
	input  wire cart_loader_pkg::init_pattern_e init_pattern,
	// Save image and sector handshake
	input  wire                                img_mounted,
	input  wire                                img_readonly,
	input  wire [63:0]                         img_size,
	input  wire                                bk_load,
	input  wire                                bk_save,
	input  wire                                sd_ack,
	output logic [7:0]                         rom_type,
	output logic [`CL_MASK_BITS-1:0]           rom_mask,
	output logic [`CL_MASK_BITS-1:0]           ram_mask,
	output logic                               pal,
	output cart_loader_pkg::cheat_code_t       cheat_code,
	output logic                               code_valid,
	output logic                               clearing,
	output logic [`CL_FILL_ADDR_BITS-1:0]      fill_addr,
	output logic [7:0]                         wram_fill_data,
	output logic [`CL_LBA_BITS-1:0]            sd_lba,
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic                               bk_busy,
	output logic                               bk_loading,
	output logic                               bk_ena
);

	import cart_loader_pkg::*;

	dl_beat_t cart_beat;
	dl_beat_t code_beat;
	logic     cart_download;
	logic     dl_start;
	logic     dl_end;

	// ==================================================================
	// Download path
	// ==================================================================
	download_router router0 (
		.clk_sys, .RESET, .dl_beat, .dl_index, .dl_active,
		.cart_beat, .code_beat, .cart_download, .dl_start, .dl_end
	);

	rom_header_parser parser0 (
		.clk_sys, .RESET, .cart_beat, .cart_download, .header_mode, .region_mode,
		.rom_type, .rom_mask, .ram_mask, .pal
	);

	cheat_code_assembler cheats0 (
		.clk_sys, .RESET, .code_beat, .cheat_code, .code_valid
	);

	// ==================================================================
	// Memory init and backup RAM
	// ==================================================================
	ram_clear_engine clear0 (
		.clk_sys, .RESET, .dl_start, .init_pattern,
		.clearing, .fill_addr, .wram_fill_data
	);

	backup_ram_sequencer backup0 (
		.clk_sys, .RESET, .cart_download, .dl_start, .dl_end, .ram_mask,
		.img_mounted, .img_readonly, .img_size, .bk_load, .bk_save, .sd_ack,
		.sd_lba, .sd_rd, .sd_wr, .bk_busy, .bk_loading, .bk_ena
	);

endmodule

`default_nettype wire

/* verif/tb_cart_loader.sv */
/*
 * Cartridge loader testbench
 * Random header, cheat, RAM clear and backup RAM stimulus checked against a model
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_loader_cfg.svh"

module tb_cart_loader;

	import cart_loader_pkg::*;

	localparam int MB = `CL_MASK_BITS;
	localparam int FB = `CL_FILL_ADDR_BITS;
	// Five header downloads and three backup downloads
	localparam int N_DOWNLOADS = 8;
	localparam longint WATCHDOG_NS = (longint'(N_DOWNLOADS) * (1 << FB) + 50000) * 8;

	logic clk_sys = 1'b0;
	logic RESET;
	dl_beat_t dl_beat;
	logic [7:0] dl_index;
	logic dl_active;
	header_mode_e header_mode;
	region_mode_e region_mode;
	init_pattern_e init_pattern;
	logic img_mounted;
	logic img_readonly;
	logic [63:0] img_size;
	logic bk_load;
	logic bk_save;
	logic sd_ack;
	logic [7:0] rom_type;
	logic [MB-1:0] rom_mask;
	logic [MB-1:0] ram_mask;
	logic pal;
	cheat_code_t cheat_code;
	logic code_valid;
	logic clearing;
	logic [FB-1:0] fill_addr;
	logic [7:0] wram_fill_data;
	logic [`CL_LBA_BITS-1:0] sd_lba;
	logic sd_rd;
	logic sd_wr;
	logic bk_busy;
	logic bk_loading;
	logic bk_ena;

	// Model state
	logic [31:0] rng_main = 32'd77312;
	logic [31:0] rng_host = 32'd77312;
	logic [7:0] exp_type;
	logic [MB-1:0] exp_rom;
	logic [MB-1:0] exp_ram;
	logic exp_region;
	cheat_code_t exp_codes [$];
	logic [`CL_LBA_BITS-1:0] lba_log [$];
	logic [1:0] kind_log [$];
	logic load_log [$];
	int errs [1:5] = '{0, 0, 0, 0, 0};
	int codes_seen = 0;
	int sweep_pos = 0;
	int sweeps_done = 0;
	int total;

	cart_loader_top dut0 (
		.clk_sys, .RESET, .dl_beat, .dl_index, .dl_active,
		.header_mode, .region_mode, .init_pattern,
		.img_mounted, .img_readonly, .img_size, .bk_load, .bk_save, .sd_ack,
		.rom_type, .rom_mask, .ram_mask, .pal, .cheat_code, .code_valid,
		.clearing, .fill_addr, .wram_fill_data,
		.sd_lba, .sd_rd, .sd_wr, .bk_busy, .bk_loading, .bk_ena
	);

	always #4 clk_sys = ~clk_sys;

	// ====================================================================
	// Model helpers and compare tasks
	// ====================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_main = xorshift32(rng_main);
		return rng_main;
	endfunction

	function automatic logic [MB-1:0] mask_of(input logic [3:0] n);
		return (MB'(1024) << n) - MB'(1);
	endfunction

	function automatic logic [7:0] pattern_byte(input logic [FB-1:0] a, input init_pattern_e p);
		case (p)
			pat_checker_ff00: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			pat_checker_6699: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			pat_fill_55:      return 8'h55;
			default:          return 8'hFF;
		endcase
	endfunction

	task automatic log_mismatch(input int test, input string name, input logic [127:0] got,
			input logic [127:0] exp);
		errs[test]++;
		$display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic log_failure(input int test, input string msg);
		errs[test]++;
		$display("Test %0d failure at %0t ns: %s", test, $time, msg);
	endtask

	task automatic check_flag(input int test, input string name, input logic got, input logic exp);
		if (got !== exp)
			log_mismatch(test, name, got, exp);
	endtask

	task automatic check_masks(input int test, input logic [7:0] type_got, type_exp,
			input logic [MB-1:0] rom_got, rom_exp, ram_got, ram_exp);
		if (type_got !== type_exp)
			log_mismatch(test, "rom_type", type_got, type_exp);
		if (rom_got !== rom_exp)
			log_mismatch(test, "rom_mask", rom_got, rom_exp);
		if (ram_got !== ram_exp)
			log_mismatch(test, "ram_mask", ram_got, ram_exp);
	endtask

	task automatic check_code(input int test, input cheat_code_t got, input cheat_code_t exp);
		if (got !== exp)
			log_mismatch(test, "cheat_code", got, exp);
	endtask

	task automatic check_fill(input int test, input logic [FB-1:0] addr_got, addr_exp,
			input logic [7:0] data_got, data_exp);
		if (addr_got !== addr_exp)
			log_mismatch(test, "fill_addr", addr_got, addr_exp);
		if (data_got !== data_exp)
			log_mismatch(test, "wram_fill_data", data_got, data_exp);
	endtask

	task automatic check_request(input int test, input logic [`CL_LBA_BITS-1:0] lba, lba_exp,
			input logic [1:0] kind, kind_exp);
		if (lba !== lba_exp)
			log_mismatch(test, "sd_lba", lba, lba_exp);
		if (kind !== kind_exp)
			log_mismatch(test, "{sd_rd,sd_wr}", kind, kind_exp);
	endtask

	task automatic finish_test(input int test, input string name);
		$display("Test %0d (%s) finished with %0d errors", test, name, errs[test]);
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================
	task automatic send_beat(input logic [24:0] addr, input logic [15:0] data,
			input logic [7:0] index, input logic wr);
		dl_beat.addr = addr;
		dl_beat.data = data;
		dl_beat.wr = wr;
		dl_index = index;
		dl_active = 1'b1;
		@(negedge clk_sys);
	endtask

	// Sparse cartridge image with model sizes from the header rules
	task automatic load_cart(input header_mode_e mode, input logic [15:0] w0);
		logic [24:0] ofs [3];
		logic [15:0] w;
		logic [3:0] rs;
		logic [3:0] ms;
		ofs[0] = 25'(`CL_LOROM_SIZE_OFS + `CL_COPIER_SKIP);
		ofs[1] = 25'(`CL_HIROM_SIZE_OFS + `CL_COPIER_SKIP);
		ofs[2] = 25'(`CL_EXHIROM_SIZE_OFS + `CL_COPIER_SKIP);
		header_mode = mode;
		init_pattern = init_pattern_e'(next_rand() % 4);
		rs = 4'(`CL_DEFAULT_ROM_SIZE);
		ms = 4'd0;
		if (mode == hdr_auto && w0[7:0] != 8'd0) begin
			rs = w0[3:0];
			ms = w0[7:4];
		end
		send_beat(25'd0, w0, 8'd0, 1'b1);
		w = 16'(next_rand());
		exp_region = w[8];
		send_beat(25'd2, w, 8'd0, 1'b1);
		// Cartridge word at the offset that closes a cheat group
		send_beat(25'd14, 16'(next_rand()), 8'd1, 1'b1);
		for (int k = 0; k < 3; k++) begin
			w = 16'(next_rand());
			if (int'(mode) == k + 2)
				rs = w[11:8];
			send_beat(ofs[k], w, 8'd0, 1'b1);
			w = 16'(next_rand());
			if (int'(mode) == k + 2)
				ms = w[3:0];
			send_beat(ofs[k] + 25'd2, w, 8'd0, 1'b1);
		end
		repeat (4) send_beat(25'(next_rand()), 16'd0, 8'd0, 1'b0);
		dl_active = 1'b0;
		case (mode)
			hdr_auto:    exp_type = w0[15:8];
			hdr_hirom:   exp_type = 8'd1;
			hdr_exhirom: exp_type = 8'd2;
			default:     exp_type = 8'd0;
		endcase
		exp_rom = mask_of(rs);
		exp_ram = (ms == 4'd0) ? '0 : mask_of(ms);
		@(negedge clk_sys);
		while (clearing)
			@(negedge clk_sys);
	endtask

	task automatic run_cheats(input int groups);
		cheat_code_t code;
		logic [31:0] r;
		logic [24:0] base;
		code = '0;
		for (int g = 0; g < groups; g++) begin
			r = next_rand();
			base = {r[20:0], 4'h0};
			for (int k = 0; k < 8; k++) begin
				r = next_rand();
				// Occasional gap with the strobe low at the closing offset
				if (r[31:29] == 3'd0)
					send_beat(base + 25'd14, r[15:0], 8'd255, 1'b0);
				code[(3 - k / 2) * 32 + (k % 2) * 16 +: 16] = r[15:0];
				if (k == 7)
					exp_codes.push_back(code);
				send_beat(base + 25'(2 * k), r[15:0], 8'(`CL_CODE_INDEX), 1'b1);
			end
		end
		dl_active = 1'b0;
		repeat (4) @(negedge clk_sys);
		if (codes_seen != groups)
			log_failure(2, $sformatf("%0d code_valid pulses for %0d groups", codes_seen, groups));
		finish_test(2, "cheat assembly");
	endtask

	task automatic verify_run(input int test, input int count, input logic [1:0] kind);
		if (lba_log.size() != count)
			log_failure(test, $sformatf("%0d sector requests seen, %0d expected",
				lba_log.size(), count));
		else
			for (int i = 0; i < count; i++) begin
				check_request(test, lba_log[i], `CL_LBA_BITS'(i), kind_log[i], kind);
				check_flag(test, "bk_loading", load_log[i], kind == 2'b10);
			end
		check_flag(test, "bk_busy", bk_busy, 1'b0);
		check_flag(test, "bk_loading", bk_loading, 1'b0);
		lba_log.delete();
		kind_log.delete();
		load_log.delete();
	endtask

	task automatic backup_after_download(input logic ro, input logic [3:0] ram_n);
		logic [31:0] r;
		r = next_rand();
		img_mounted = 1'b1;
		img_readonly = ro;
		img_size = {32'd0, r} | 64'd1;
		load_cart(hdr_auto, {r[15:8], ram_n, r[3:0] | 4'd1});
		check_flag(4, "bk_ena", bk_ena, !ro && ram_n != 4'd0);
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		repeat (30) @(negedge clk_sys);
		if (ro || ram_n == 4'd0)
			verify_run(4, 0, 2'b10);
		else
			verify_run(4, int'(exp_ram[MB-1:9]) + 1, 2'b10);
	endtask

	task automatic manual_run(input logic save);
		if (save)
			bk_save = 1'b1;
		else
			bk_load = 1'b1;
		@(negedge clk_sys);
		while (!bk_busy)
			@(negedge clk_sys);
		// Opposite request during the run
		if (save)
			bk_load = 1'b1;
		else
			bk_save = 1'b1;
		repeat (3) @(negedge clk_sys);
		bk_load = 1'b0;
		bk_save = 1'b0;
		while (bk_busy)
			@(negedge clk_sys);
		repeat (30) @(negedge clk_sys);
		verify_run(5, int'(exp_ram[MB-1:9]) + 1, save ? 2'b01 : 2'b10);
	endtask

	// ====================================================================
	// Host sector model and output monitors
	// ====================================================================
	always begin : host_model
		@(negedge clk_sys);
		if ((sd_rd || sd_wr) && !sd_ack) begin
			lba_log.push_back(sd_lba);
			kind_log.push_back({sd_rd, sd_wr});
			load_log.push_back(bk_loading);
			rng_host = xorshift32(rng_host);
			repeat (1 + rng_host % 20) @(negedge clk_sys);
			sd_ack = 1'b1;
			while (sd_rd || sd_wr)
				@(negedge clk_sys);
			sd_ack = 1'b0;
		end
	end

	always @(negedge clk_sys) begin : output_monitor
		if (!RESET) begin
			if (code_valid) begin
				codes_seen++;
				if (exp_codes.size() == 0)
					log_failure(2, "code_valid pulsed with no cheat group sent");
				else
					check_code(2, cheat_code, exp_codes.pop_front());
			end
			if (clearing) begin
				check_fill(3, fill_addr, FB'(sweep_pos), wram_fill_data,
					pattern_byte(FB'(sweep_pos), init_pattern));
				sweep_pos++;
			end else if (sweep_pos != 0) begin
				if (sweep_pos != (1 << FB))
					log_failure(3, $sformatf("clear sweep lasted %0d cycles", sweep_pos));
				sweeps_done++;
				sweep_pos = 0;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

	initial begin : main_sequence
		RESET = 1'b1;
		dl_beat = '0;
		dl_index = 8'd0;
		dl_active = 1'b0;
		header_mode = hdr_auto;
		region_mode = region_auto;
		init_pattern = pat_fill_55;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = 64'd0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		sd_ack = 1'b0;
		repeat (10) @(negedge clk_sys);
		RESET = 1'b0;
		check_flag(1, "reset outputs",
			|{clearing, code_valid, sd_rd, sd_wr, bk_busy, bk_loading, bk_ena}, 1'b0);

		for (int m = 0; m < 5; m++) begin
			load_cart(header_mode_e'(m), 16'(next_rand()));
			check_masks(1, rom_type, exp_type, rom_mask, exp_rom, ram_mask, exp_ram);
			for (int r = 0; r < 3; r++) begin
				region_mode = region_mode_e'(r);
				repeat (2) @(negedge clk_sys);
				check_flag(1, "pal", pal, (r == 0) ? exp_region : (r == 2));
			end
		end
		finish_test(1, "header parsing");

		run_cheats(6);

		backup_after_download(1'b1, 4'd2);
		backup_after_download(1'b0, 4'd0);
		backup_after_download(1'b0, 4'd1 + 4'(next_rand() % 3));
		finish_test(4, "backup load after download");

		manual_run(1'b1);
		manual_run(1'b0);
		finish_test(5, "manual save and load");

		if (sweeps_done != N_DOWNLOADS)
			log_failure(3, $sformatf("%0d clear sweeps for %0d downloads",
				sweeps_done, N_DOWNLOADS));
		finish_test(3, "work RAM clear");

		total = 0;
		for (int t = 1; t <= 5; t++)
			total += errs[t];
		$display("Tests run: 5, errors: %0d", total);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
source/cart_loader_pkg.sv
source/download_router.sv
source/rom_header_parser.sv
source/cheat_code_assembler.sv
source/ram_clear_engine.sv
source/backup_ram_sequencer.sv
source/cart_loader_top.sv
verif/tb_cart_loader.sv
